/* hw/fetch_align.sv */
////////////////////////////////////////////////////////////////////////////
// output stage of the prefetcher
//   - head word from data slot 0 or straight from memory
//   - realigned word for 16-bit aligned instructions
//   - pop strobe for both queues
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "fetch_cfg.svh"

module fetch_align (
  // address queue
  input  fetch_pkg::addr_t          addr_slot_i [`FETCH_DEPTH],
  input  logic [`FETCH_DEPTH-1:0]   addr_valid_i,
  // data queue
  input  fetch_pkg::word_t          data_slot_i [`FETCH_DEPTH],
  input  logic [`FETCH_DEPTH-1:0]   data_valid_i,
  // raw memory response, used as bypass
  input  logic                      mem_rvalid_i,
  input  fetch_pkg::word_t          mem_rdata_i,
  // decoder side
  input  logic                      ready_i,
  output fetch_pkg::fetch_rsp_t     rsp_o,
  output logic                      unaligned_valid_o,
  output fetch_pkg::word_t          unaligned_rdata_o,
  output logic                      pop_o
);

  localparam int HALF_W = $bits(fetch_pkg::word_t) / 2;

  logic             head_valid;
  fetch_pkg::word_t head_rdata;
  fetch_pkg::word_t next_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // head word
  ////////////////////////////////////////////////////////////////////////////

  // an rvalid always belongs to the oldest address still missing data,
  // which is slot 0 whenever data slot 0 is empty
  assign head_valid = data_valid_i[0] || (addr_valid_i[0] && mem_rvalid_i);
  assign head_rdata = data_valid_i[0] ? data_slot_i[0] : mem_rdata_i;

  always_comb begin
    rsp_o.valid = head_valid;
    rsp_o.rdata = head_rdata;
    // address was queued when the request went out, so it is already here
    rsp_o.addr  = addr_slot_i[0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // realigned word
  ////////////////////////////////////////////////////////////////////////////

  // second word comes from slot 1 or from the bypass
  assign next_rdata = data_valid_i[1] ? data_slot_i[1] : mem_rdata_i;

  // addr slot 1 only fills once slot 0 has its data, so a valid here
  // implies a valid head
  assign unaligned_valid_o = data_valid_i[1] || (addr_valid_i[1] && mem_rvalid_i);

  // lower half of the next word above the upper half of the head
  assign unaligned_rdata_o = {next_rdata[HALF_W-1:0], head_rdata[2*HALF_W-1:HALF_W]};

  // head consumed this cycle
  assign pop_o = head_valid && ready_i;

endmodule

/* hw/fetch_cfg.svh */
////////////////////////////////////////////////////////////////////////////
// configuration macros for the instruction prefetch front end
//   - slot count of the address and data queues
//   - byte distance between two sequential fetch addresses
////////////////////////////////////////////////////////////////////////////

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// number of slots in each queue
// the unaligned word is built from slot 1, so anything below 2 breaks it
`define FETCH_DEPTH 2

// one 32-bit word per fetch, byte addressed
`define FETCH_STEP 4

// note that both queues always share the same depth, since every data
// slot pairs with the address slot at the same index

`endif

/* hw/fetch_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// memory-side control of the prefetcher
//   - next fetch address selection
//   - request/grant/rvalid FSM with redirect abort
//   - push control for the address and data queues
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "fetch_cfg.svh"

module fetch_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  // core side
  input  logic                      req_i,
  input  logic                      clear_i,
  input  fetch_pkg::addr_t          addr_i,
  // queue status
  input  fetch_pkg::addr_t          addr_slot_i [`FETCH_DEPTH],
  input  logic [`FETCH_DEPTH-1:0]   addr_valid_i,
  input  logic                      data_full_i,
  // instruction memory
  input  logic                      mem_gnt_i,
  input  logic                      mem_rvalid_i,
  output fetch_pkg::mem_req_t       mem_req_o,
  // queue pushes
  output logic                      addr_push_o,
  output fetch_pkg::addr_t          addr_push_data_o,
  output logic                      data_push_o
);

  fetch_pkg::fetch_state_e state_q, state_d;

  fetch_pkg::addr_t last_addr;
  fetch_pkg::addr_t addr_next;
  // where sequential fetching resumes once the address queue is empty
  fetch_pkg::addr_t resume_addr_q;
  logic             can_issue;

  ////////////////////////////////////////////////////////////////////////////
  // next address
  ////////////////////////////////////////////////////////////////////////////

  // valid slots are contiguous from 0, the highest one is the newest
  always_comb begin
    last_addr = addr_slot_i[0];
    for (int i = 1; i < `FETCH_DEPTH; i++) begin
      if (addr_valid_i[i]) begin
        last_addr = addr_slot_i[i];
      end
    end
  end

  always_comb begin
    if (clear_i) begin
      addr_next = addr_i;
    end else if (|addr_valid_i) begin
      addr_next = last_addr + fetch_pkg::addr_t'(`FETCH_STEP);
    end else begin
      // queue drained, or a redirect target not issued yet
      addr_next = resume_addr_q;
    end
  end

  // room for one more address; a clear frees the whole queue
  assign can_issue = req_i && (clear_i || !addr_valid_i[`FETCH_DEPTH-1]);

  assign addr_push_data_o = addr_next;

  ////////////////////////////////////////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mem_req_o.req  = 1'b0;
    mem_req_o.addr = addr_next;
    addr_push_o    = 1'b0;
    data_push_o    = 1'b0;
    state_d        = state_q;

    unique case (state_q)
      fetch_pkg::IDLE: begin
        if (can_issue) begin
          mem_req_o.req = 1'b1;
          addr_push_o   = 1'b1;
          state_d       = mem_gnt_i ? fetch_pkg::WAIT_RVALID : fetch_pkg::WAIT_GNT;
        end
      end

      fetch_pkg::WAIT_GNT: begin
        if (clear_i) begin
          // pending request was never granted, retarget it
          if (can_issue) begin
            mem_req_o.req = 1'b1;
            addr_push_o   = 1'b1;
            state_d       = mem_gnt_i ? fetch_pkg::WAIT_RVALID : fetch_pkg::WAIT_GNT;
          end else begin
            state_d = fetch_pkg::IDLE;
          end
        end else begin
          // hold the queued address until granted
          mem_req_o.req  = 1'b1;
          mem_req_o.addr = last_addr;
          if (mem_gnt_i) begin
            state_d = fetch_pkg::WAIT_RVALID;
          end
        end
      end

      fetch_pkg::WAIT_RVALID: begin
        if (mem_rvalid_i) begin
          // response to an address flushed this cycle is dropped
          data_push_o = !clear_i && !data_full_i;
          if (can_issue) begin
            mem_req_o.req = 1'b1;
            addr_push_o   = 1'b1;
            state_d       = mem_gnt_i ? fetch_pkg::WAIT_RVALID : fetch_pkg::WAIT_GNT;
          end else begin
            state_d = fetch_pkg::IDLE;
          end
        end else if (clear_i) begin
          // granted word still owed, nothing new goes out until it lands
          state_d = fetch_pkg::WAIT_ABORTED;
        end
      end

      fetch_pkg::WAIT_ABORTED: begin
        // stale response arrives, throw it away and restart
        if (mem_rvalid_i) begin
          if (can_issue) begin
            mem_req_o.req = 1'b1;
            addr_push_o   = 1'b1;
            state_d       = mem_gnt_i ? fetch_pkg::WAIT_RVALID : fetch_pkg::WAIT_GNT;
          end else begin
            state_d = fetch_pkg::IDLE;
          end
        end
      end

      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= fetch_pkg::IDLE;
      resume_addr_q <= '0;
    end else begin
      state_q <= state_d;
      if (addr_push_o) begin
        resume_addr_q <= addr_next + fetch_pkg::addr_t'(`FETCH_STEP);
      end else if (clear_i) begin
        resume_addr_q <= addr_i;
      end
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(state_q) && state_q inside {fetch_pkg::IDLE, fetch_pkg::WAIT_GNT,
                                            fetch_pkg::WAIT_RVALID,
                                            fetch_pkg::WAIT_ABORTED});

  a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o.req |-> mem_req_o.addr[1:0] == 2'b00);

  // data is only stored while its address is still queued
  // so a word owed to a flushed address never reaches the data queue
  a_no_stale_push: assert property (@(posedge clk) disable iff (!rst_n)
    data_push_o |-> |addr_valid_i);

endmodule

/* hw/fetch_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types of the prefetch front end
//   - address and instruction word types
//   - response bundle toward the decoder
//   - request bundle toward instruction memory
//   - fetch FSM state encoding
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  // byte address, always word aligned when it leaves the prefetcher
  typedef logic [31:0] addr_t;

  // raw instruction word as returned by memory
  typedef logic [31:0] word_t;

  // head word presented to the decoder
  typedef struct packed {
    logic  valid;
    word_t rdata;
    addr_t addr;
  } fetch_rsp_t;

  // address phase toward instruction memory
  // accepted when req and the grant are high together
  typedef struct packed {
    logic  req;
    addr_t addr;
  } mem_req_t;

  // memory-side fetch states
  //   WAIT_ABORTED drops the one response still owed after a redirect
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } fetch_state_e;

endpackage

/* hw/fetch_slot_queue.sv */
////////////////////////////////////////////////////////////////////////////
// slot queue for the prefetcher, generic in its payload
//   - push fills the lowest free slot
//   - pop shifts every slot one step toward index 0
//   - flush empties it, keeping a same-cycle push in slot 0
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "fetch_cfg.svh"

module fetch_slot_queue #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush_i,
  input  logic                      push_i,
  input  payload_t                  push_data_i,
  input  logic                      pop_i,
  output payload_t                  slot_o [`FETCH_DEPTH],
  output logic [`FETCH_DEPTH-1:0]   slot_valid_o,
  output logic                      full_o
);

  // slot 0 is the head
  payload_t                slot_q   [`FETCH_DEPTH];
  payload_t                slot_int [`FETCH_DEPTH];
  payload_t                slot_d   [`FETCH_DEPTH];
  logic [`FETCH_DEPTH-1:0] valid_q, valid_int, valid_d;

  // push into the first free slot
  always_comb begin
    logic placed;
    placed    = 1'b0;
    slot_int  = slot_q;
    valid_int = valid_q;
    if (push_i) begin
      for (int i = 0; i < `FETCH_DEPTH; i++) begin
        if (!valid_q[i] && !placed) begin
          slot_int[i]  = push_data_i;
          valid_int[i] = 1'b1;
          placed       = 1'b1;
        end
      end
    end
  end

  // shift on pop, flush overrides everything
  always_comb begin
    slot_d  = slot_int;
    valid_d = valid_int;
    if (pop_i) begin
      for (int i = 0; i < `FETCH_DEPTH-1; i++) begin
        slot_d[i]  = slot_int[i+1];
        valid_d[i] = valid_int[i+1];
      end
      // last slot keeps stale payload, only its valid drops
      valid_d[`FETCH_DEPTH-1] = 1'b0;
    end
    if (flush_i) begin
      valid_d    = '0;
      valid_d[0] = push_i;
      slot_d[0]  = push_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    slot_q <= slot_d;
  end

  assign slot_o       = slot_q;
  assign slot_valid_o = valid_q;
  assign full_o       = valid_q[`FETCH_DEPTH-1];

  // the controller must check for room before pushing
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_i && !flush_i |-> !full_o);

  // a pop on an empty queue is only legal with a bypassed push in the same cycle
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i && !flush_i |-> (valid_q[0] || push_i));

endmodule

/* hw/prefetch_top.sv */
////////////////////////////////////////////////////////////////////////////
// instruction prefetch front end
//   - fetch control toward instruction memory
//   - address and data slot queues
//   - output stage toward the decoder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "fetch_cfg.svh"

module prefetch_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // core side
  input  logic                  req_i,
  input  logic                  clear_i,
  input  fetch_pkg::addr_t      addr_i,
  input  logic                  ready_i,
  output fetch_pkg::fetch_rsp_t rsp_o,
  output logic                  unaligned_valid_o,
  output fetch_pkg::word_t      unaligned_rdata_o,
  // instruction memory
  output fetch_pkg::mem_req_t   mem_req_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  fetch_pkg::word_t      mem_rdata_i
);

  // address queue
  fetch_pkg::addr_t        addr_slot [`FETCH_DEPTH];
  logic [`FETCH_DEPTH-1:0] addr_valid;
  logic                    addr_push;
  fetch_pkg::addr_t        addr_push_data;

  // data queue
  fetch_pkg::word_t        data_slot [`FETCH_DEPTH];
  logic [`FETCH_DEPTH-1:0] data_valid;
  logic                    data_full;
  logic                    data_push;

  // head consumed, pops both queues
  logic                    pop;

  fetch_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_i            (req_i),
    .clear_i          (clear_i),
    .addr_i           (addr_i),
    .addr_slot_i      (addr_slot),
    .addr_valid_i     (addr_valid),
    .data_full_i      (data_full),
    .mem_gnt_i        (mem_gnt_i),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_req_o        (mem_req_o),
    .addr_push_o      (addr_push),
    .addr_push_data_o (addr_push_data),
    .data_push_o      (data_push)
  );

  // fullness of the address queue is taken from its slot valids
  fetch_slot_queue #(.payload_t(fetch_pkg::addr_t)) addr_q (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (clear_i),
    .push_i       (addr_push),
    .push_data_i  (addr_push_data),
    .pop_i        (pop),
    .slot_o       (addr_slot),
    .slot_valid_o (addr_valid),
    .full_o       ()
  );

  fetch_slot_queue #(.payload_t(fetch_pkg::word_t)) data_q (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (clear_i),
    .push_i       (data_push),
    .push_data_i  (mem_rdata_i),
    .pop_i        (pop),
    .slot_o       (data_slot),
    .slot_valid_o (data_valid),
    .full_o       (data_full)
  );

  fetch_align u_align (
    .addr_slot_i       (addr_slot),
    .addr_valid_i      (addr_valid),
    .data_slot_i       (data_slot),
    .data_valid_i      (data_valid),
    .mem_rvalid_i      (mem_rvalid_i),
    .mem_rdata_i       (mem_rdata_i),
    .ready_i           (ready_i),
    .rsp_o             (rsp_o),
    .unaligned_valid_o (unaligned_valid_o),
    .unaligned_rdata_o (unaligned_rdata_o),
    .pop_o             (pop)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the prefetch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
  --top-module tb_prefetch \
  -f vlog.f \
  -Mdir build/obj_dir \
  -o tb_prefetch

# the exit status of the simulation is the result
./build/obj_dir/tb_prefetch

/* verification/prefetch_testdata.txt */
# M index word        : memory image word at a word index (index decimal, word hex)
# T name target count : redirect to target (hex byte address), then consume count words
M 0 00000013
M 1 00100093
M 2 00208113
M 3 12345678
M 4 cafe0197
M 5 8067beef
M 8 fedcba98
M 16 0000a001
M 17 4501c02e
M 24 deadbeef
M 40 00c58533
M 48 ffc10113
T seq_from_zero 000 10
T jump_mid 040 6
T short_one 0a0 1
T short_two 010 2
T abort_chain 0c0 1
T back_long 020 12
T short_pair 080 2
T tail_run 0b0 8
T single_again 004 1
T final_run 060 9

/* verification/tb_prefetch.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the instruction prefetch front end
//   - clock, reset and idle output checks
//   - instruction memory model with random grant and rvalid latency
//   - redirect tests read from the test data file
//   - address, data and realigned word checks at every consume
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "fetch_cfg.svh"

module tb_prefetch;

  localparam int MEM_WORDS = 64;
  localparam int MAX_TESTS = 16;

  logic                  clk;
  logic                  rst_n;
  logic                  req_i;
  logic                  clear_i;
  fetch_pkg::addr_t      addr_i;
  logic                  ready_i;
  fetch_pkg::fetch_rsp_t rsp_o;
  logic                  unaligned_valid_o;
  fetch_pkg::word_t      unaligned_rdata_o;
  fetch_pkg::mem_req_t   mem_req_o;
  logic                  mem_gnt_i;
  logic                  mem_rvalid_i;
  fetch_pkg::word_t      mem_rdata_i;

  // memory image and test list
  fetch_pkg::word_t image [MEM_WORDS];
  string            t_name   [MAX_TESTS];
  fetch_pkg::addr_t t_target [MAX_TESTS];
  int               t_count  [MAX_TESTS];
  int               n_tests;
  int               total_words;

  // consumes that came with a valid realigned word
  int unal_checks;

  // run length guard
  int cycle_count;
  int cycle_limit = 100000;

  // decoder stall stretch still to go
  int unsigned stall_left;

  // memory model state
  logic             pend;
  int unsigned      delay;
  fetch_pkg::addr_t pend_addr;
  logic             wait_gnt;
  fetch_pkg::addr_t wait_addr;

  prefetch_top uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (req_i),
    .clear_i           (clear_i),
    .addr_i            (addr_i),
    .ready_i           (ready_i),
    .rsp_o             (rsp_o),
    .unaligned_valid_o (unaligned_valid_o),
    .unaligned_rdata_o (unaligned_rdata_o),
    .mem_req_o         (mem_req_o),
    .mem_gnt_i         (mem_gnt_i),
    .mem_rvalid_i      (mem_rvalid_i),
    .mem_rdata_i       (mem_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string detail);
    $display("%0s", detail);
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    fail_run($sformatf("mismatch %0s %0s expected %08h actual %08h", test, what, exp, act));
  endtask

  // image lookup, wraps on the byte address
  function automatic fetch_pkg::word_t image_word(input fetch_pkg::addr_t a);
    return image[a[7:2]];
  endfunction

  // mostly ready, with the odd long stall to fill the queues
  task automatic roll_ready(output logic rdy);
    int unsigned r;
    r = $urandom_range(99);
    if (stall_left > 0) begin
      stall_left--;
      rdy = 1'b0;
    end else if (r < 6) begin
      stall_left = $urandom_range(16, 6);
      rdy = 1'b0;
    end else begin
      rdy = (r < 75);
    end
  endtask

  task automatic check_idle_outputs(input string phase);
    logic [2:0] act;
    act = {mem_req_o.req, rsp_o.valid, unaligned_valid_o};
    assert (act === 3'b000)
    else report_mismatch(phase, "req/valid/unaligned", 32'h0, 32'(act));
  endtask

  task automatic load_testdata();
    int                  fd;
    int                  rc;
    int                  idx;
    string               tok;
    string               name;
    fetch_pkg::word_t    word;
    fetch_pkg::addr_t    target;
    int                  count;
    logic [8*256-1:0]    skip_line;
    // words not named in the file still differ at every address
    for (int i = 0; i < MEM_WORDS; i++) begin
      image[i] = 32'h9e3779b9 * fetch_pkg::word_t'(i + 1);
    end
    n_tests     = 0;
    total_words = 0;
    fd = $fopen("verification/prefetch_testdata.txt", "r");
    assert (fd != 0) else fail_run("cannot open the test data file");
    while (!$feof(fd)) begin
      tok = "";
      rc  = $fscanf(fd, "%s", tok);
      if (rc != 1) begin
        break;
      end
      if (tok == "M") begin
        rc = $fscanf(fd, "%d %h", idx, word);
        assert (rc == 2 && idx >= 0 && idx < MEM_WORDS)
        else fail_run("malformed memory line in the test data file");
        image[idx] = word;
      end else if (tok == "T") begin
        rc = $fscanf(fd, "%s %h %d", name, target, count);
        assert (rc == 3 && n_tests < MAX_TESTS && count > 0)
        else fail_run("malformed or surplus test line in the test data file");
        t_name[n_tests]   = name;
        t_target[n_tests] = target;
        t_count[n_tests]  = count;
        total_words       = total_words + count;
        n_tests++;
      end else begin
        // comment line
        rc = $fgets(skip_line, fd);
      end
    end
    $fclose(fd);
    assert (n_tests > 0) else fail_run("the test data file holds no tests");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one redirect test
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    fetch_pkg::addr_t exp_addr;
    fetch_pkg::word_t head_w;
    fetch_pkg::word_t next_w;
    fetch_pkg::word_t exp_unal;
    int               consumed;
    logic             rdy;
    consumed = 0;
    // one-cycle redirect, decoder held off during it
    req_i   <= 1'b1;
    clear_i <= 1'b1;
    addr_i  <= t_target[t];
    ready_i <= 1'b0;
    @(posedge clk);
    clear_i <= 1'b0;
    // addr_i only counts together with clear_i
    addr_i  <= fetch_pkg::addr_t'($urandom()) & 32'hffff_fffc;
    roll_ready(rdy);
    ready_i <= rdy;
    while (consumed < t_count[t]) begin
      @(posedge clk);
      if (rsp_o.valid && ready_i) begin
        exp_addr = t_target[t] + fetch_pkg::addr_t'(`FETCH_STEP * consumed);
        head_w   = image_word(exp_addr);
        next_w   = image_word(exp_addr + fetch_pkg::addr_t'(`FETCH_STEP));
        exp_unal = {next_w[15:0], head_w[31:16]};
        assert (rsp_o.addr == exp_addr)
        else report_mismatch(t_name[t], "addr", exp_addr, rsp_o.addr);
        assert (rsp_o.rdata == head_w)
        else report_mismatch(t_name[t], "rdata", head_w, rsp_o.rdata);
        if (unaligned_valid_o) begin
          assert (unaligned_rdata_o == exp_unal)
          else report_mismatch(t_name[t], "unaligned", exp_unal, unaligned_rdata_o);
          unal_checks++;
        end
        consumed++;
      end
      roll_ready(rdy);
      ready_i <= rdy;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction memory model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    pend         = 1'b0;
    wait_gnt     = 1'b0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        mem_gnt_i    <= 1'b0;
        mem_rvalid_i <= 1'b0;
        pend          = 1'b0;
        wait_gnt      = 1'b0;
      end else begin
        // ungranted request holds its address unless redirected
        if (wait_gnt && !clear_i) begin
          assert (mem_req_o.req && mem_req_o.addr == wait_addr)
          else fail_run("protocol error: request dropped or moved before its grant");
        end
        assert (!(mem_req_o.req && pend))
        else fail_run("protocol error: new request while a response is outstanding");
        wait_gnt  = mem_req_o.req && !mem_gnt_i;
        wait_addr = mem_req_o.addr;
        if (mem_req_o.req && mem_gnt_i) begin
          pend      = 1'b1;
          delay     = $urandom_range(2);
          pend_addr = mem_req_o.addr;
        end
        // response 1 to 3 cycles after the grant cycle
        if (pend && delay == 0) begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= image_word(pend_addr);
          pend          = 1'b0;
        end else begin
          if (pend) begin
            delay--;
          end
          mem_rvalid_i <= 1'b0;
          mem_rdata_i  <= $urandom();
        end
        mem_gnt_i <= ($urandom_range(99) < 65);
      end
    end
  end

  // timeout
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      assert (cycle_count < cycle_limit)
      else fail_run($sformatf("timeout: run not done after %0d cycles", cycle_count));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(28));
    rst_n       = 1'b0;
    req_i       = 1'b0;
    clear_i     = 1'b0;
    addr_i      = '0;
    ready_i     = 1'b0;
    stall_left  = 0;
    unal_checks = 0;
    load_testdata();
    cycle_limit = 200 + 12 * total_words;

    // 16 reset cycles, the first edge only settles the registers
    @(posedge clk);
    repeat (15) begin
      @(posedge clk);
      check_idle_outputs("reset");
    end
    rst_n <= 1'b1;
    @(posedge clk);
    check_idle_outputs("after_reset");

    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end

    // stalls fill both queues, so the realigned word must show up
    if (unal_checks > 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      fail_run("the realigned word was never valid at a consume");
    end
  end

endmodule

/* vlog.f */
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_slot_queue.sv
hw/fetch_align.sv
hw/fetch_ctrl.sv
hw/prefetch_top.sv
verification/tb_prefetch.sv
